//--- include/elink_consts.svh
//////////////////////////////
// Sizes shared by the E-link lane blocks
// Include wherever a width or depth is needed
//////////////////////////////

`ifndef ELINK_CONSTS_SVH
`define ELINK_CONSTS_SVH

// Transmit FIFO depth in words
`define FIFO_DEPTH 16

// Occupancy at which the writer is told to hold off
`define FIFO_PFULL 12

// One 8b10b symbol
`define SYM_WIDTH 10

// Bits carried per lane clock
`define LANE_WIDTH 2

// Delimiter plus data byte
`define WORD_WIDTH 10

`endif

//--- src/elinkFramePkg.sv
//////////////////////////////
// Frame content types
// Delimiter codes and K-character bytes
//////////////////////////////

package elinkFramePkg;

  // Upper two bits of a FIFO word, also the received ISK code
  typedef enum logic [1:0]
  {
    DELIM_DATA  = 2'b00,
    DELIM_EOP   = 2'b01,
    DELIM_SOP   = 2'b10,
    DELIM_COMMA = 2'b11
  } delimType;

  // K28.y bytes as HGF EDCBA
  typedef enum logic [7:0]
  {
    K28_1 = 8'h3C,
    K28_6 = 8'hDC,
    K28_5 = 8'hBC
  } kCharType;

endpackage

//--- src/elinkLinkPkg.sv
//////////////////////////////
// Lane timing and alignment types
//////////////////////////////

package elinkLinkPkg;

  // Five 2-bit beats per symbol
  typedef enum logic [2:0]
  {
    PH0, PH1, PH2, PH3, PH4
  } serPhaseType;

  // Receive symbol boundary search
  typedef enum logic [1:0]
  {
    ALIGN_SEARCH,
    ALIGN_CONFIRM,
    ALIGN_LOCKED
  } alignStateType;

endpackage

//--- src/elinkTxFifo.sv
//////////////////////////////
// Transmit word FIFO with partial-full level
// Read data is valid in the cycle of fifoRe
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module elinkTxFifo
(
  input  logic                   bitCLKx2,
  input  logic                   reset,
  input  logic                   efifoWr,
  input  logic [`WORD_WIDTH-1:0] efifoDin,
  input  logic                   fifoRe,
  output logic [`WORD_WIDTH-1:0] fifoDout,
  output logic                   fifoEmpty,
  output logic                   efifoPfull
);

  localparam int PtrWidth = $clog2(`FIFO_DEPTH);

  logic [`WORD_WIDTH-1:0] mem [`FIFO_DEPTH];
  logic [PtrWidth-1:0]    wrPtr;
  logic [PtrWidth-1:0]    rdPtr;
  logic [PtrWidth:0]      count;
  logic                   full;
  logic                   wrOk;
  logic                   rdOk;

  assign full       = (count == `FIFO_DEPTH);
  assign fifoEmpty  = (count == 0);
  assign efifoPfull = (count >= `FIFO_PFULL);
  assign wrOk       = efifoWr && !full;
  assign rdOk       = fifoRe && !fifoEmpty;

  // Head word shown without a read latency
  assign fifoDout = mem[rdPtr];

  always_ff @(posedge bitCLKx2)
  begin
    if (wrOk)
    begin
      mem[wrPtr] <= efifoDin;
    end
  end

  always_ff @(posedge bitCLKx2)
  begin
    if (reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrOk)
        wrPtr <= wrPtr + 1'b1;
      if (rdOk)
        rdPtr <= rdPtr + 1'b1;
      count <= count + wrOk - rdOk;
    end
  end

  noWriteWhenFull: assert property (@(posedge bitCLKx2) disable iff (reset)
    efifoWr |-> !full);

  noReadWhenEmpty: assert property (@(posedge bitCLKx2) disable iff (reset)
    fifoRe |-> !fifoEmpty);

endmodule

//--- src/enc8b10b.sv
//////////////////////////////
// 8b10b encoder, one symbol per request
// Sends K28.5 when the FIFO is empty
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module enc8b10b import elinkFramePkg::*;
(
  input  logic                   bitCLKx2,
  input  logic                   reset,
  input  logic                   symReq,
  input  logic [`WORD_WIDTH-1:0] fifoDout,
  input  logic                   fifoEmpty,
  output logic                   fifoRe,
  output logic [`SYM_WIDTH-1:0]  symOut,
  output logic                   symValid
);

  logic       rdPos;
  logic       rd6;
  logic       rdNext;
  logic       isK;
  logic [7:0] byteVal;
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] code6;
  logic [3:0] code4;
  delimType   delim;

  assign fifoRe = symReq && !fifoEmpty;

  always_comb
  begin
    delim = fifoEmpty ? DELIM_COMMA : delimType'(fifoDout[9:8]);
    isK   = 1'b1;
    case (delim)
      DELIM_DATA:
      begin
        byteVal = fifoDout[7:0];
        isK     = 1'b0;
      end
      DELIM_SOP: byteVal = K28_1;
      DELIM_EOP: byteVal = K28_6;
      default:   byteVal = K28_5;
    endcase
    x = byteVal[4:0];
    y = byteVal[7:5];

    // 5b6b as abcdei for negative disparity
    case (x)
      5'd0:  code6 = 6'b100111;
      5'd1:  code6 = 6'b011101;
      5'd2:  code6 = 6'b101101;
      5'd3:  code6 = 6'b110001;
      5'd4:  code6 = 6'b110101;
      5'd5:  code6 = 6'b101001;
      5'd6:  code6 = 6'b011001;
      5'd7:  code6 = 6'b111000;
      5'd8:  code6 = 6'b111001;
      5'd9:  code6 = 6'b100101;
      5'd10: code6 = 6'b010101;
      5'd11: code6 = 6'b110100;
      5'd12: code6 = 6'b001101;
      5'd13: code6 = 6'b101100;
      5'd14: code6 = 6'b011100;
      5'd15: code6 = 6'b010111;
      5'd16: code6 = 6'b011011;
      5'd17: code6 = 6'b100011;
      5'd18: code6 = 6'b010011;
      5'd19: code6 = 6'b110010;
      5'd20: code6 = 6'b001011;
      5'd21: code6 = 6'b101010;
      5'd22: code6 = 6'b011010;
      5'd23: code6 = 6'b111010;
      5'd24: code6 = 6'b110011;
      5'd25: code6 = 6'b100110;
      5'd26: code6 = 6'b010110;
      5'd27: code6 = 6'b110110;
      5'd28: code6 = isK ? 6'b001111 : 6'b001110;
      5'd29: code6 = 6'b101110;
      5'd30: code6 = 6'b011110;
      default: code6 = 6'b101011;
    endcase
    // D.7 is balanced but still alternates
    if (rdPos && ($countones(code6) != 3 || (x == 5'd7 && !isK)))
      code6 = ~code6;
    rd6 = ($countones(code6) != 3) ? !rdPos : rdPos;

    // 3b4b as fghj for negative disparity after the 6b block
    case (y)
      3'd0: code4 = 4'b1011;
      3'd1: code4 = 4'b1001;
      3'd2: code4 = 4'b0101;
      3'd3: code4 = 4'b1100;
      3'd4: code4 = 4'b1101;
      3'd5: code4 = 4'b1010;
      3'd6: code4 = 4'b0110;
      default:
        // Alternate D.x.7 avoids a run of five
        if ((!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
            (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)))
          code4 = 4'b0111;
        else
          code4 = 4'b1110;
    endcase
    if (isK)
      code4 = rd6 ? code4 : ~code4;
    else if (rd6 && ($countones(code4) != 2 || y == 3'd3))
      code4 = ~code4;
    rdNext = ($countones(code4) != 2) ? !rd6 : rd6;
  end

  always_ff @(posedge bitCLKx2)
  begin
    if (reset)
    begin
      rdPos    <= 1'b0;
      symValid <= 1'b0;
    end
    else
    begin
      symValid <= symReq;
      if (symReq)
        rdPos <= rdNext;
    end
  end

  always_ff @(posedge bitCLKx2)
  begin
    if (symReq)
      symOut <= {code6, code4};
  end

  disparityBalanced: assert property (@(posedge bitCLKx2) disable iff (reset)
    symValid |->
      ($countones(symOut) == 5 && rdPos == $past(rdPos)) ||
      ($countones(symOut) == 6 && !$past(rdPos) && rdPos) ||
      ($countones(symOut) == 4 && $past(rdPos) && !rdPos));

endmodule

//--- src/elinkSerializer.sv
//////////////////////////////
// Symbol to 2-bit lane, MSB pair first
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module elinkSerializer import elinkLinkPkg::*;
(
  input  logic                   bitCLKx2,
  input  logic                   reset,
  input  logic [`SYM_WIDTH-1:0]  symOut,
  input  logic                   symValid,
  output logic                   symReq,
  output logic [`LANE_WIDTH-1:0] elink2bit
);

  serPhaseType           phase;
  logic [`SYM_WIDTH-1:0] shiftReg;

  // Request at beat 3, encoder answers during beat 4
  assign symReq    = (phase == PH3);
  assign elink2bit = shiftReg[`SYM_WIDTH-1 -: `LANE_WIDTH];

  always_ff @(posedge bitCLKx2)
  begin
    if (reset)
    begin
      phase    <= PH0;
      shiftReg <= '0;
    end
    else
    begin
      phase <= (phase == PH4) ? PH0 : serPhaseType'(phase + 3'd1);
      // New symbol enters so that beat 0 shows its first pair
      if (symValid)
        shiftReg <= symOut;
      else
        shiftReg <= shiftReg << `LANE_WIDTH;
    end
  end

  validAtLastBeat: assert property (@(posedge bitCLKx2) disable iff (reset)
    symValid |-> phase == PH4 && $past(phase) == PH3);

endmodule

//--- src/elinkDeserializer.sv
//////////////////////////////
// 2-bit lane to aligned symbols
// Locks on K28.5 seen twice, ten bits apart
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module elinkDeserializer import elinkLinkPkg::*;
(
  input  logic                   bitCLKx2,
  input  logic                   reset,
  input  logic [`LANE_WIDTH-1:0] elink2bit,
  output logic [`SYM_WIDTH-1:0]  symIn,
  output logic                   symStrobe,
  output logic                   rxAligned
);

  localparam logic [`SYM_WIDTH-1:0] CommaNeg = 10'b0011111010;
  localparam logic [`SYM_WIDTH-1:0] CommaPos = 10'b1100000101;

  // Enough history for both bit offsets within a beat
  logic [`SYM_WIDTH+`LANE_WIDTH-2:0] hist;
  logic [`SYM_WIDTH-1:0]             win0;
  logic [`SYM_WIDTH-1:0]             win1;
  logic [`SYM_WIDTH-1:0]             winSel;
  logic                              comma0;
  logic                              comma1;
  logic                              hit;
  logic                              miss;
  logic                              bitOff;
  logic [1:0]                        missCnt;
  serPhaseType                       phase;
  alignStateType                     state;

  assign win0   = hist[`SYM_WIDTH-1:0];
  assign win1   = hist[`SYM_WIDTH:1];
  assign comma0 = (win0 == CommaNeg) || (win0 == CommaPos);
  assign comma1 = (win1 == CommaNeg) || (win1 == CommaPos);
  assign winSel = bitOff ? win1 : win0;

  // Expected boundary versus a comma anywhere else
  assign hit  = (phase == PH0) && (bitOff ? comma1 : comma0);
  assign miss = !hit && (comma0 || comma1);

  assign rxAligned = (state == ALIGN_LOCKED);

  always_ff @(posedge bitCLKx2)
  begin
    if (reset)
    begin
      hist      <= '0;
      phase     <= PH0;
      state     <= ALIGN_SEARCH;
      bitOff    <= 1'b0;
      missCnt   <= '0;
      symStrobe <= 1'b0;
    end
    else
    begin
      hist      <= {hist[`SYM_WIDTH-2:0], elink2bit};
      phase     <= (phase == PH4) ? PH0 : serPhaseType'(phase + 3'd1);
      symStrobe <= 1'b0;
      case (state)
        ALIGN_SEARCH:
          if (comma0 || comma1)
          begin
            bitOff <= !comma0;
            phase  <= PH1;
            state  <= ALIGN_CONFIRM;
          end
        ALIGN_CONFIRM:
          if (phase == PH0)
          begin
            state     <= hit ? ALIGN_LOCKED : ALIGN_SEARCH;
            symStrobe <= hit;
            missCnt   <= '0;
          end
        default:
        begin
          symStrobe <= (phase == PH0);
          if (hit)
            missCnt <= '0;
          else if (miss)
            missCnt <= missCnt + 2'd1;
          // Third misplaced comma in a row
          if (miss && missCnt == 2'd2)
            state <= ALIGN_SEARCH;
        end
      endcase
    end
  end

  always_ff @(posedge bitCLKx2)
  begin
    symIn <= winSel;
  end

  // Once locked, commas only show up on the symbol boundary
  commaOnBoundary: assert property (@(posedge bitCLKx2) disable iff (reset)
    rxAligned && (comma0 || comma1) |-> hit);

endmodule

//--- src/dec8b10b.sv
//////////////////////////////
// 8b10b decoder with disparity check
// Idle commas produce no output
//////////////////////////////

`timescale 1ns/1ns

module dec8b10b import elinkFramePkg::*;
(
  input  logic       bitCLKx2,
  input  logic       reset,
  input  logic [9:0] symIn,
  input  logic       symStrobe,
  output logic [7:0] rxData,
  output logic [1:0] rxIsk,
  output logic       rxValid,
  output logic       rxCodeErr
);

  logic       rdPos;
  logic       rd6;
  logic       rdNext;
  logic       isK;
  logic       isComma;
  logic       err;
  logic [5:0] c6;
  logic [3:0] c4;
  logic [3:0] k4;
  logic [4:0] x;
  logic [2:0] y;
  delimType   isk;

  assign c6      = symIn[9:4];
  assign c4      = symIn[3:0];
  assign isComma = (symIn == 10'b0011111010) || (symIn == 10'b1100000101);

  always_comb
  begin
    err = 1'b0;
    isK = 1'b0;
    case (c6)
      6'b100111, 6'b011000: x = 5'd0;
      6'b011101, 6'b100010: x = 5'd1;
      6'b101101, 6'b010010: x = 5'd2;
      6'b110001:            x = 5'd3;
      6'b110101, 6'b001010: x = 5'd4;
      6'b101001:            x = 5'd5;
      6'b011001:            x = 5'd6;
      6'b111000, 6'b000111: x = 5'd7;
      6'b111001, 6'b000110: x = 5'd8;
      6'b100101:            x = 5'd9;
      6'b010101:            x = 5'd10;
      6'b110100:            x = 5'd11;
      6'b001101:            x = 5'd12;
      6'b101100:            x = 5'd13;
      6'b011100:            x = 5'd14;
      6'b010111, 6'b101000: x = 5'd15;
      6'b011011, 6'b100100: x = 5'd16;
      6'b100011:            x = 5'd17;
      6'b010011:            x = 5'd18;
      6'b110010:            x = 5'd19;
      6'b001011:            x = 5'd20;
      6'b101010:            x = 5'd21;
      6'b011010:            x = 5'd22;
      6'b111010, 6'b000101: x = 5'd23;
      6'b110011, 6'b001100: x = 5'd24;
      6'b100110:            x = 5'd25;
      6'b010110:            x = 5'd26;
      6'b110110, 6'b001001: x = 5'd27;
      6'b001110:            x = 5'd28;
      6'b101110, 6'b010001: x = 5'd29;
      6'b011110, 6'b100001: x = 5'd30;
      6'b101011, 6'b010100: x = 5'd31;
      6'b001111, 6'b110000:
      begin
        x   = 5'd28;
        isK = 1'b1;
      end
      default:
      begin
        x   = 5'd0;
        err = 1'b1;
      end
    endcase
    // Running disparity entering each sub-block
    if (($countones(c6) == 4 || c6 == 6'b111000) && rdPos)
      err = 1'b1;
    if (($countones(c6) == 2 || c6 == 6'b000111) && !rdPos)
      err = 1'b1;
    rd6 = ($countones(c6) != 3) ? !rdPos : rdPos;

    // K28 fghj follows the polarity of its 6b block
    k4 = (c6 == 6'b001111) ? c4 : ~c4;
    case (isK ? k4 : c4)
      4'b1011, 4'b0100:                   y = 3'd0;
      4'b1001:                            y = 3'd1;
      4'b0101:                            y = 3'd2;
      4'b1100, 4'b0011:                   y = 3'd3;
      4'b1101, 4'b0010:                   y = 3'd4;
      4'b1010:                            y = 3'd5;
      4'b0110:                            y = 3'd6;
      default:                            y = 3'd7;
    endcase
    if (!isK && (($countones(c4) == 3 || c4 == 4'b1100) && rd6))
      err = 1'b1;
    if (!isK && (($countones(c4) == 1 || c4 == 4'b0011) && !rd6))
      err = 1'b1;
    if ($countones(c4) == 0 || $countones(c4) == 4)
      err = 1'b1;
    if (isK && !(y == 3'd1 || y == 3'd5 || y == 3'd6))
      err = 1'b1;
    rdNext = ($countones(c4) != 2) ? !rd6 : rd6;

    if (!isK)
      isk = DELIM_DATA;
    else if (y == 3'd1)
      isk = DELIM_SOP;
    else if (y == 3'd6)
      isk = DELIM_EOP;
    else
      isk = DELIM_COMMA;
  end

  always_ff @(posedge bitCLKx2)
  begin
    if (reset)
    begin
      rdPos     <= 1'b0;
      rxValid   <= 1'b0;
      rxCodeErr <= 1'b0;
    end
    else
    begin
      rxValid   <= symStrobe && !isComma;
      rxCodeErr <= symStrobe && !isComma && err;
      // A comma tells the transmitter's disparity directly
      if (symStrobe)
        rdPos <= isComma ? (symIn[9:8] == 2'b00) : rdNext;
    end
  end

  always_ff @(posedge bitCLKx2)
  begin
    if (symStrobe)
    begin
      rxData <= {y, x};
      rxIsk  <= isk;
    end
  end

endmodule

//--- src/elinkLoopback.sv
//////////////////////////////
// E-link lane loop, FIFO to encoder to lane
// and back through the receiver
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module elinkLoopback
(
  input  logic                   bitCLKx2,
  input  logic                   reset,
  input  logic                   efifoWr,
  input  logic [`WORD_WIDTH-1:0] efifoDin,
  output logic                   efifoPfull,
  output logic [`LANE_WIDTH-1:0] elink2bit,
  output logic [7:0]             rxData,
  output logic [1:0]             rxIsk,
  output logic                   rxValid,
  output logic                   rxCodeErr,
  output logic                   rxAligned
);

  logic [`WORD_WIDTH-1:0] fifoDout;
  logic                   fifoRe;
  logic                   fifoEmpty;
  logic [`SYM_WIDTH-1:0]  symOut;
  logic                   symValid;
  logic                   symReq;
  logic [`SYM_WIDTH-1:0]  symIn;
  logic                   symStrobe;

  elinkTxFifo txFifo_i
  (
    .bitCLKx2   (bitCLKx2),
    .reset      (reset),
    .efifoWr    (efifoWr),
    .efifoDin   (efifoDin),
    .fifoRe     (fifoRe),
    .fifoDout   (fifoDout),
    .fifoEmpty  (fifoEmpty),
    .efifoPfull (efifoPfull)
  );

  enc8b10b enc_i
  (
    .bitCLKx2  (bitCLKx2),
    .reset     (reset),
    .symReq    (symReq),
    .fifoDout  (fifoDout),
    .fifoEmpty (fifoEmpty),
    .fifoRe    (fifoRe),
    .symOut    (symOut),
    .symValid  (symValid)
  );

  elinkSerializer ser_i
  (
    .bitCLKx2  (bitCLKx2),
    .reset     (reset),
    .symOut    (symOut),
    .symValid  (symValid),
    .symReq    (symReq),
    .elink2bit (elink2bit)
  );

  // Lane looped straight back into the receiver
  elinkDeserializer deser_i
  (
    .bitCLKx2  (bitCLKx2),
    .reset     (reset),
    .elink2bit (elink2bit),
    .symIn     (symIn),
    .symStrobe (symStrobe),
    .rxAligned (rxAligned)
  );

  dec8b10b dec_i
  (
    .bitCLKx2  (bitCLKx2),
    .reset     (reset),
    .symIn     (symIn),
    .symStrobe (symStrobe),
    .rxData    (rxData),
    .rxIsk     (rxIsk),
    .rxValid   (rxValid),
    .rxCodeErr (rxCodeErr)
  );

endmodule

//--- verif/elinkChecker.sv
//////////////////////////////
// Scoreboard for the E-link loopback
// Queues FIFO writes and matches them to rxValid pulses
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module elinkChecker
  import elinkFramePkg::*;
(
  input  logic                   bitCLKx2,
  input  logic                   reset,
  input  logic                   efifoWr,
  input  logic [`WORD_WIDTH-1:0] efifoDin,
  input  logic                   efifoPfull,
  input  logic [`LANE_WIDTH-1:0] elink2bit,
  input  logic [7:0]             rxData,
  input  logic [1:0]             rxIsk,
  input  logic                   rxValid,
  input  logic                   rxCodeErr,
  input  logic                   rxAligned,
  input  logic [8*24-1:0]        testName,
  input  logic                   testEnd,
  output int                     errorCount,
  output int                     pendingCount,
  output int                     wordCount,
  output int                     testCount
);

  // K28.5 for negative and positive running disparity
  localparam logic [`SYM_WIDTH-1:0] CommaRdNeg = 10'b0011111010;
  localparam logic [`SYM_WIDTH-1:0] CommaRdPos = 10'b1100000101;
  localparam int                    SymBeats   = `SYM_WIDTH / `LANE_WIDTH;

  logic [`WORD_WIDTH-1:0] expected [$];
  logic [`WORD_WIDTH-1:0] head;
  logic [`SYM_WIDTH-1:0]  laneBits;
  logic [`SYM_WIDTH-1:0]  lastComma;
  bit                     commaSeen;
  bit                     anyWrite;
  bit                     wasAligned;
  int                     beatsSinceComma;
  int                     written;
  int                     received;
  int                     outstanding;
  int                     testWords;
  int                     testErrors;

  // K-characters come back as their K28 byte, not the written byte
  function automatic logic [7:0] receivedByteFor(input logic [`WORD_WIDTH-1:0] word);
    case (delimType'(word[9:8]))
      DELIM_SOP: return K28_1;
      DELIM_EOP: return K28_6;
      default:   return word[7:0];
    endcase
  endfunction

  task automatic flagError(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errorCount++;
    testErrors++;
  endtask

  always @(posedge bitCLKx2)
  begin
    if (!reset)
    begin
      outstanding = written - received;
      if (rxValid)
      begin
        if (expected.size() == 0)
          flagError($sformatf("rxValid with isk %0d data %02h but no word is pending",
                              rxIsk, rxData));
        else
        begin
          head = expected.pop_front();
          received++;
          wordCount++;
          testWords++;
          if (rxIsk != head[9:8] || rxData != receivedByteFor(head))
            flagError($sformatf("got isk %0d data %02h, expected isk %0d data %02h",
                                rxIsk, rxData, head[9:8], receivedByteFor(head)));
        end
      end
      if (rxCodeErr)
        flagError("rxCodeErr raised on a received symbol");
      // Occupancy can never exceed words written but not yet received
      if (efifoPfull && outstanding < `FIFO_PFULL)
        flagError($sformatf("efifoPfull high with only %0d words outstanding", outstanding));
      if (wasAligned && !rxAligned)
        flagError("rxAligned dropped after lock");
      wasAligned = rxAligned;

      // Lane commas sit on the symbol grid, idle ones alternate polarity
      laneBits = {laneBits[`SYM_WIDTH-`LANE_WIDTH-1:0], elink2bit};
      beatsSinceComma++;
      if (laneBits == CommaRdNeg || laneBits == CommaRdPos)
      begin
        if (commaSeen && beatsSinceComma % SymBeats != 0)
          flagError("comma on elink2bit off the symbol boundary");
        else if (commaSeen && !anyWrite &&
                 (beatsSinceComma != SymBeats || laneBits == lastComma))
          flagError("idle commas on elink2bit do not alternate every symbol");
        commaSeen       = 1'b1;
        lastComma       = laneBits;
        beatsSinceComma = 0;
      end

      if (efifoWr)
      begin
        expected.push_back(efifoDin);
        written++;
        anyWrite = 1'b1;
      end
      pendingCount = expected.size();
      if (testEnd)
      begin
        testCount++;
        $display("test %0s: %0d words received, %0d errors", testName, testWords, testErrors);
        testWords  = 0;
        testErrors = 0;
      end
    end
  end

endmodule

//--- verif/tbElinkLoopback.sv
//////////////////////////////
// Testbench for the E-link loopback
// Replays verif/elink_tests.txt into the FIFO write port
//////////////////////////////

`timescale 1ns/1ns
`include "elink_consts.svh"

module tbElinkLoopback
  import elinkFramePkg::*;
();

  logic                   bitCLKx2;
  logic                   reset;
  logic                   efifoWr;
  logic [`WORD_WIDTH-1:0] efifoDin;
  logic                   efifoPfull;
  logic [`LANE_WIDTH-1:0] elink2bit;
  logic [7:0]             rxData;
  logic [1:0]             rxIsk;
  logic                   rxValid;
  logic                   rxCodeErr;
  logic                   rxAligned;
  logic [8*24-1:0]        testName;
  logic                   testEnd;
  logic [31:0]            lcgState;
  logic                   pfullSeen;
  int                     errorCount;
  int                     pendingCount;
  int                     wordCount;
  int                     testCount;
  int                     tbErrors;
  int                     totalWords;
  int                     totalGaps;
  int                     cycleCount;
  int                     cycleLimit;

  elinkLoopback elinkLoopback_i
  (
    .bitCLKx2   (bitCLKx2),
    .reset      (reset),
    .efifoWr    (efifoWr),
    .efifoDin   (efifoDin),
    .efifoPfull (efifoPfull),
    .elink2bit  (elink2bit),
    .rxData     (rxData),
    .rxIsk      (rxIsk),
    .rxValid    (rxValid),
    .rxCodeErr  (rxCodeErr),
    .rxAligned  (rxAligned)
  );

  elinkChecker checker_i
  (
    .bitCLKx2     (bitCLKx2),
    .reset        (reset),
    .efifoWr      (efifoWr),
    .efifoDin     (efifoDin),
    .efifoPfull   (efifoPfull),
    .elink2bit    (elink2bit),
    .rxData       (rxData),
    .rxIsk        (rxIsk),
    .rxValid      (rxValid),
    .rxCodeErr    (rxCodeErr),
    .rxAligned    (rxAligned),
    .testName     (testName),
    .testEnd      (testEnd),
    .errorCount   (errorCount),
    .pendingCount (pendingCount),
    .wordCount    (wordCount),
    .testCount    (testCount)
  );

  initial
  begin
    bitCLKx2 = 1'b0;
    forever #2 bitCLKx2 = ~bitCLKx2;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic idleCycles(input int n);
    repeat (n) @(negedge bitCLKx2);
  endtask

  // Writer holds off while the FIFO reports partial full
  task automatic writeWord(input logic [`WORD_WIDTH-1:0] word);
    if (efifoPfull)
      pfullSeen = 1'b1;
    while (efifoPfull)
      @(negedge bitCLKx2);
    efifoWr  = 1'b1;
    efifoDin = word;
    @(negedge bitCLKx2);
    efifoWr  = 1'b0;
  endtask

  task automatic pressureBurst(input int n, input logic [7:0] first);
    logic [7:0] value;
    value     = first;
    pfullSeen = 1'b0;
    repeat (n)
    begin
      writeWord({DELIM_DATA, value});
      value = value + 8'd1;
    end
    // Writer outpaces the lane fivefold, so the level must be hit
    if (n >= 2 * `FIFO_PFULL && !pfullSeen)
    begin
      $display("efifoPfull never rose during a back-pressure burst of %0d words", n);
      tbErrors++;
    end
  endtask

  task automatic randomBurst(input int n);
    int       written;
    delimType delim;
    written = 0;
    while (written < n)
    begin
      lcgState = lcgNext(lcgState);
      delim    = delimType'(lcgState[23:22]);
      if (delim == DELIM_COMMA)
        delim = DELIM_DATA;
      if (lcgState[21])
      begin
        writeWord({delim, lcgState[31:24]});
        written++;
      end
      else
        idleCycles(1);
    end
  endtask

  // Let the lane empty, then close the test in the checker
  task automatic finishTest(input logic [8*24-1:0] name);
    while (pendingCount != 0)
      @(negedge bitCLKx2);
    idleCycles(10);
    testName = name;
    testEnd  = 1'b1;
    @(negedge bitCLKx2);
    testEnd  = 1'b0;
  endtask

  // Dry pass only sums words and gaps for the timeout
  task automatic playFile(input bit dryRun);
    int              fd;
    int              n;
    bit              started;
    logic [8*128-1:0] lineBuf;
    logic [8*8-1:0]  cmd;
    logic [8*24-1:0] nameBuf;
    logic [8*24-1:0] current;
    logic [31:0]     a;
    logic [31:0]     b;
    started = 1'b0;
    current = '0;
    fd = $fopen("verif/elink_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test file verif/elink_tests.txt");
      tbErrors++;
      return;
    end
    while (!$feof(fd))
    begin
      cmd     = '0;
      lineBuf = '0;
      a       = '0;
      b       = '0;
      n = $fgets(lineBuf, fd);
      n = $sscanf(lineBuf, "%s %h %h", cmd, a, b);
      if (cmd == "T")
      begin
        n = $sscanf(lineBuf, "%s %s", cmd, nameBuf);
        if (!dryRun && started)
          finishTest(current);
        current = nameBuf;
        started = 1'b1;
      end
      else if (cmd == "W")
      begin
        if (dryRun)
          totalWords++;
        else
          writeWord({a[1:0], b[7:0]});
      end
      else if (cmd == "G")
      begin
        if (dryRun)
          totalGaps += a;
        else
          idleCycles(a);
      end
      else if (cmd == "R")
      begin
        if (dryRun)
          totalWords += a;
        else
          randomBurst(a);
      end
      else if (cmd == "B")
      begin
        if (dryRun)
          totalWords += a;
        else
          pressureBurst(a, b[7:0]);
      end
      else if (cmd != '0 && cmd[7:0] != "#" && dryRun)
      begin
        $display("Unrecognized record %0s in the test file", cmd);
        tbErrors++;
      end
    end
    $fclose(fd);
    if (!dryRun && started)
      finishTest(current);
  endtask

  always @(posedge bitCLKx2)
  begin
    cycleCount++;
    if (cycleLimit != 0 && cycleCount >= cycleLimit)
    begin
      $display("Timeout after %0d cycles with %0d written words not yet received",
               cycleCount, pendingCount);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    reset      = 1'b1;
    efifoWr    = 1'b0;
    efifoDin   = '0;
    testName   = '0;
    testEnd    = 1'b0;
    lcgState   = 32'd24;
    pfullSeen  = 1'b0;
    tbErrors   = 0;
    totalWords = 0;
    totalGaps  = 0;
    cycleCount = 0;
    cycleLimit = 0;
    playFile(1'b1);
    cycleLimit = 5 * (totalWords + totalGaps) + 200;
    idleCycles(2);
    reset = 1'b0;
    // Idle commas alone must bring the receiver to lock
    while (!rxAligned)
      @(negedge bitCLKx2);
    playFile(1'b0);
    idleCycles(20);
    $display("Totals: %0d tests, %0d words received, %0d errors",
             testCount, wordCount, errorCount + tbErrors);
    if (pendingCount != 0)
      $display("%0d written words were never received", pendingCount);
    if (errorCount == 0 && tbErrors == 0 && pendingCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verif/elink_tests.txt
# Records: T name | W delim byte | G idleCycles | R words | B words firstByte
# Numbers are hex; delim 0 data, 1 EOP, 2 SOP
T resetAlign
G 40
T dataWords
W 0 00
W 0 ff
W 0 a5
W 0 5a
W 0 3c
W 0 bc
W 0 7c
W 0 07
W 0 f1
W 0 eb
W 0 1c
T framing
W 2 00
W 0 11
W 0 22
W 0 33
W 1 00
W 2 00
W 0 fc
W 1 00
T idleGaps
W 2 00
W 0 44
G 30
W 0 55
G 7
W 1 00
G 60
T backPressure
B 40 80
T byteSweep
B 100 00
T randomBurst
R c8

//--- flist.f
+incdir+include
src/elinkFramePkg.sv
src/elinkLinkPkg.sv
src/elinkTxFifo.sv
src/enc8b10b.sv
src/elinkSerializer.sv
src/elinkDeserializer.sv
src/dec8b10b.sv
src/elinkLoopback.sv
verif/elinkChecker.sv
verif/tbElinkLoopback.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tbElinkLoopback
FLIST := flist.f
LOG   := sim.log
OBJ   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)
